// ==== common/enigma_sym_pkg.sv ====
//====================
// enigma symbol definitions
// symbol width, rotor depth, reflector constant and symbol types
//====================

`default_nettype none

package enigma_sym_pkg;

    // 6-bit symbols, one rotor entry per symbol value
    parameter int SYM_W       = 6;
    parameter int TABLE_DEPTH = 64;

    // reflector maps x to REFLECT_MAX - x
    parameter int REFLECT_MAX = 63;

    // one symbol or one table index
    typedef logic [SYM_W-1:0] sym_t;

    // rotor A advance per symbol, 0 to 3
    typedef logic [1:0] step_t;

endpackage

`default_nettype wire

// ==== common/enigma_ctrl_pkg.sv ====
//====================
// enigma control definitions
// control FSM states, table select and crypt mode encodings
//====================

`default_nettype none

package enigma_ctrl_pkg;

    typedef enum logic [1:0] {
        ST_IDLE  = 2'd0,
        ST_LOAD  = 2'd1,
        ST_READY = 2'd2
    } ctrl_state_t;

    // code 0 is accepted on the bus but writes nothing
    typedef enum logic [1:0] {
        SEL_NONE    = 2'd0,
        SEL_ROTOR_A = 2'd1,
        SEL_ROTOR_B = 2'd2
    } table_sel_t;

    typedef enum logic {
        MODE_ENCRYPT = 1'b0,
        MODE_DECRYPT = 1'b1
    } crypt_mode_t;

endpackage

`default_nettype wire

// ==== logic/enigma_ctrl.sv ====
//====================
// enigma control
// load/ready FSM, shared rotor write pointer and accept flag
//====================

`timescale 1ns/1ns
`default_nettype none

module enigma_ctrl (
    input  logic                        clk,
    input  logic                        srst_n,
    input  logic                        load_i,
    input  logic                        encrypt_i,
    input  enigma_ctrl_pkg::table_sel_t table_sel_i,
    output logic                        wr_en_a_o,
    output logic                        wr_en_b_o,
    output enigma_sym_pkg::sym_t        wr_addr_o,
    output logic                        accept_o
);

    localparam enigma_sym_pkg::sym_t LAST_IDX =
        enigma_sym_pkg::sym_t'(enigma_sym_pkg::TABLE_DEPTH - 1);

    enigma_ctrl_pkg::ctrl_state_t state_q;
    enigma_ctrl_pkg::ctrl_state_t state_d;
    enigma_sym_pkg::sym_t         wr_ptr_q;
    logic                         load_en;

    //==================== FSM
    always_comb begin
        state_d = state_q;
        case (state_q)
            enigma_ctrl_pkg::ST_IDLE: begin
                if (load_i) begin
                    state_d = enigma_ctrl_pkg::ST_LOAD;
                end
            end
            enigma_ctrl_pkg::ST_LOAD: begin
                if (!load_i) begin
                    state_d = enigma_ctrl_pkg::ST_READY;
                end
            end
            // ready is left only through reset
            default: state_d = state_q;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!srst_n) begin
            state_q <= enigma_ctrl_pkg::ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    //==================== table writes
    // load is honoured in idle and load states
    assign load_en   = load_i && (state_q != enigma_ctrl_pkg::ST_READY);
    assign wr_en_a_o = load_en && (table_sel_i == enigma_ctrl_pkg::SEL_ROTOR_A);
    assign wr_en_b_o = load_en && (table_sel_i == enigma_ctrl_pkg::SEL_ROTOR_B);
    assign wr_addr_o = wr_ptr_q;

    // one pointer shared by both rotors
    // wraps after the last entry
    always_ff @(posedge clk) begin
        if (!srst_n) begin
            wr_ptr_q <= '0;
        end else if (wr_en_a_o || wr_en_b_o) begin
            if (wr_ptr_q == LAST_IDX) begin
                wr_ptr_q <= '0;
            end else begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
        end
    end

    //==================== accept
    always_ff @(posedge clk) begin
        if (!srst_n) begin
            accept_o <= 1'b0;
        end else begin
            accept_o <= encrypt_i && (state_q == enigma_ctrl_pkg::ST_READY);
        end
    end

    // load ends only after both rotors are fully written
    a_full_load: assert property (@(posedge clk) disable iff (!srst_n)
        (state_q == enigma_ctrl_pkg::ST_LOAD && !load_i) |-> wr_ptr_q == '0);

endmodule

`default_nettype wire

// ==== rotor/rotor_table.sv ====
//====================
// rotor table
// 64-entry permutation store with forward and inverse lookup
//====================

`timescale 1ns/1ns
`default_nettype none

module rotor_table #(
    parameter int SYM_W = enigma_sym_pkg::SYM_W
) (
    input  logic                 clk,
    input  logic                 srst_n,
    input  logic                 wr_en_i,
    input  enigma_sym_pkg::sym_t wr_addr_i,
    input  enigma_sym_pkg::sym_t wr_data_i,
    input  enigma_sym_pkg::sym_t fwd_idx_i,
    output enigma_sym_pkg::sym_t fwd_o,
    input  enigma_sym_pkg::sym_t inv_val_i,
    output enigma_sym_pkg::sym_t inv_o
);

    // one entry per symbol value
    localparam int DEPTH = 2 ** SYM_W;

    enigma_sym_pkg::sym_t mem_q [DEPTH];

    //==================== storage
    // flops, the inverse search reads every entry at once
    always_ff @(posedge clk) begin
        if (!srst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem_q[i] <= '0;
            end
        end else if (wr_en_i) begin
            mem_q[wr_addr_i] <= wr_data_i;
        end
    end

    //==================== lookups
    assign fwd_o = mem_q[fwd_idx_i];

    // search for the entry holding inv_val_i
    // a loaded permutation has exactly one match, otherwise 0 when none
    always_comb begin
        inv_o = '0;
        for (int i = 0; i < DEPTH; i++) begin
            if (mem_q[i] == inv_val_i) begin
                inv_o = enigma_sym_pkg::sym_t'(i);
            end
        end
    end

endmodule

`default_nettype wire

// ==== rotor/scramble_path.sv ====
//====================
// scramble path
// input stages, rotor A with offset, rotor B, reflector, inverse
// path and registered output
//====================

`timescale 1ns/1ns
`default_nettype none

module scramble_path #(
    parameter int SYM_W = enigma_sym_pkg::SYM_W
) (
    input  logic                         clk,
    input  logic                         srst_n,
    input  logic                         accept_i,
    input  enigma_sym_pkg::sym_t         code_i,
    input  enigma_ctrl_pkg::crypt_mode_t crypt_mode_i,
    input  logic                         wr_en_a_i,
    input  logic                         wr_en_b_i,
    input  enigma_sym_pkg::sym_t         wr_addr_i,
    output enigma_sym_pkg::sym_t         code_o,
    output logic                         code_valid_o
);

    localparam enigma_sym_pkg::sym_t REFLECT =
        enigma_sym_pkg::sym_t'(enigma_sym_pkg::REFLECT_MAX);

    enigma_sym_pkg::sym_t         in_sym_q;
    enigma_ctrl_pkg::crypt_mode_t in_mode_q;
    enigma_sym_pkg::sym_t         sym_q;
    enigma_ctrl_pkg::crypt_mode_t mode_q;
    logic                         vld_q;
    enigma_sym_pkg::sym_t         offset_q;

    enigma_sym_pkg::sym_t a_idx;
    enigma_sym_pkg::sym_t a_fwd;
    enigma_sym_pkg::sym_t b_fwd;
    enigma_sym_pkg::sym_t refl;
    enigma_sym_pkg::sym_t b_inv;
    enigma_sym_pkg::sym_t a_inv;
    enigma_sym_pkg::sym_t result;
    enigma_sym_pkg::step_t step;

    //==================== input stages
    // sampled on the same edge as the accept flag in ctrl
    always_ff @(posedge clk) begin
        in_sym_q  <= code_i;
        in_mode_q <= crypt_mode_i;
    end

    // second stage holds the symbol being looked up
    always_ff @(posedge clk) begin
        if (accept_i) begin
            sym_q  <= in_sym_q;
            mode_q <= in_mode_q;
        end
    end

    always_ff @(posedge clk) begin
        if (!srst_n) begin
            vld_q <= 1'b0;
        end else begin
            vld_q <= accept_i;
        end
    end

    //==================== rotors
    // rotor A also takes the inverse of rotor B's output
    rotor_table #(
        .SYM_W (SYM_W)
    ) rotor_a_i (
        .clk       (clk),
        .srst_n    (srst_n),
        .wr_en_i   (wr_en_a_i),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (code_i),
        .fwd_idx_i (a_idx),
        .fwd_o     (a_fwd),
        .inv_val_i (b_inv),
        .inv_o     (a_inv)
    );

    rotor_table #(
        .SYM_W (SYM_W)
    ) rotor_b_i (
        .clk       (clk),
        .srst_n    (srst_n),
        .wr_en_i   (wr_en_b_i),
        .wr_addr_i (wr_addr_i),
        .wr_data_i (code_i),
        .fwd_idx_i (a_fwd),
        .fwd_o     (b_fwd),
        .inv_val_i (refl),
        .inv_o     (b_inv)
    );

    // forward, reflect, back
    assign a_idx  = sym_q - offset_q;
    assign refl   = REFLECT - b_fwd;
    assign result = a_inv + offset_q;

    // encrypt steps on the forward A output, decrypt on the inverse B output
    // both are the same value for a matching pair of symbols
    assign step = (mode_q == enigma_ctrl_pkg::MODE_DECRYPT) ? b_inv[1:0] : a_fwd[1:0];

    //==================== output and offset
    always_ff @(posedge clk) begin
        if (!srst_n) begin
            offset_q     <= '0;
            code_o       <= '0;
            code_valid_o <= 1'b0;
        end else begin
            code_valid_o <= vld_q;
            if (vld_q) begin
                offset_q <= offset_q + enigma_sym_pkg::sym_t'(step);
                code_o   <= result;
            end
        end
    end

    // rotors stay put while a symbol is in the lookup stage
    a_no_write_in_lookup: assert property (@(posedge clk) disable iff (!srst_n)
        vld_q |-> !(wr_en_a_i || wr_en_b_i));

endmodule

`default_nettype wire

// ==== logic/enigma_top.sv ====
//====================
// enigma top
// two-rotor cipher engine, control and scramble path
//====================

`timescale 1ns/1ns
`default_nettype none

module enigma_top #(
    parameter int SYM_W = enigma_sym_pkg::SYM_W
) (
    input  logic                         clk,
    input  logic                         srst_n,
    input  logic                         load_i,
    input  logic                         encrypt_i,
    input  enigma_ctrl_pkg::crypt_mode_t crypt_mode_i,
    input  enigma_ctrl_pkg::table_sel_t  table_sel_i,
    input  enigma_sym_pkg::sym_t         code_i,
    output enigma_sym_pkg::sym_t         code_o,
    output logic                         code_valid_o
);

    logic                 wr_en_a;
    logic                 wr_en_b;
    enigma_sym_pkg::sym_t wr_addr;
    logic                 accept;

    enigma_ctrl ctrl_i (
        .clk         (clk),
        .srst_n      (srst_n),
        .load_i      (load_i),
        .encrypt_i   (encrypt_i),
        .table_sel_i (table_sel_i),
        .wr_en_a_o   (wr_en_a),
        .wr_en_b_o   (wr_en_b),
        .wr_addr_o   (wr_addr),
        .accept_o    (accept)
    );

    // code_i is both the load data and the symbol stream
    scramble_path #(
        .SYM_W (SYM_W)
    ) path_i (
        .clk          (clk),
        .srst_n       (srst_n),
        .accept_i     (accept),
        .code_i       (code_i),
        .crypt_mode_i (crypt_mode_i),
        .wr_en_a_i    (wr_en_a),
        .wr_en_b_i    (wr_en_b),
        .wr_addr_i    (wr_addr),
        .code_o       (code_o),
        .code_valid_o (code_valid_o)
    );

endmodule

`default_nettype wire

// ==== dv/enigma_model.svh ====
//====================
// enigma reference model
// rotor tables, rotor A offset, per-symbol cipher rule and LFSR
//====================

`ifndef ENIGMA_MODEL_SVH
`define ENIGMA_MODEL_SVH

localparam logic [31:0] LFSR_SEED = 32'hd5d1c483;
localparam logic [31:0] LFSR_TAPS = 32'h80200003;
localparam int          TBL_N     = enigma_sym_pkg::TABLE_DEPTH;

logic [31:0] lfsr_q = LFSR_SEED;

int model_a     [TBL_N];
int model_b     [TBL_N];
int model_a_inv [TBL_N];
int model_b_inv [TBL_N];
int model_offset = 0;

// galois LFSR, one step per bit taken
function automatic int rand_bits(int n);
    int   val;
    logic out;
    val = 0;
    for (int i = 0; i < n; i++) begin
        out = lfsr_q[0];
        lfsr_q = lfsr_q >> 1;
        if (out) begin
            lfsr_q = lfsr_q ^ LFSR_TAPS;
        end
        val = (val << 1) | int'(out);
    end
    return val;
endfunction

// fisher-yates on both rotors, then the inverse tables
function automatic void shuffle_tables();
    int j;
    int tmp;
    for (int i = 0; i < TBL_N; i++) begin
        model_a[i] = i;
        model_b[i] = i;
    end
    for (int i = TBL_N - 1; i > 0; i--) begin
        j = rand_bits(12) % (i + 1);
        tmp = model_a[i];
        model_a[i] = model_a[j];
        model_a[j] = tmp;
        j = rand_bits(12) % (i + 1);
        tmp = model_b[i];
        model_b[i] = model_b[j];
        model_b[j] = tmp;
    end
    for (int i = 0; i < TBL_N; i++) begin
        model_a_inv[model_a[i]] = i;
        model_b_inv[model_b[i]] = i;
    end
endfunction

// one symbol through A, B, reflector, inverse B, inverse A
function automatic int model_crypt(int sym, bit decrypt);
    int a_out;
    int b_out;
    int refl;
    int b_back;
    int res;
    a_out  = model_a[(sym - model_offset) & (TBL_N - 1)];
    b_out  = model_b[a_out];
    refl   = enigma_sym_pkg::REFLECT_MAX - b_out;
    b_back = model_b_inv[refl];
    res    = (model_a_inv[b_back] + model_offset) & (TBL_N - 1);
    // step taken between A and B on the path that matches the mode
    if (decrypt) begin
        model_offset = (model_offset + (b_back & 3)) & (TBL_N - 1);
    end else begin
        model_offset = (model_offset + (a_out & 3)) & (TBL_N - 1);
    end
    return res;
endfunction

`endif

// ==== dv/enigma_tb.sv ====
//====================
// enigma testbench
// loads random rotors, runs encrypt and decrypt streams against a model
//====================

`timescale 1ns/1ns
`default_nettype none

module enigma_tb;

    localparam int SYM_W         = enigma_sym_pkg::SYM_W;
    localparam int DEPTH         = enigma_sym_pkg::TABLE_DEPTH;
    localparam int BURST_LEN     = 48;
    localparam int DRAIN_TIMEOUT = 16;

    logic                         clk;
    logic                         srst_n;
    logic                         load_i;
    logic                         encrypt_i;
    enigma_ctrl_pkg::crypt_mode_t crypt_mode_i;
    enigma_ctrl_pkg::table_sel_t  table_sel_i;
    enigma_sym_pkg::sym_t         code_i;
    enigma_sym_pkg::sym_t         code_o;
    logic                         code_valid_o;

    int cyc = 0;
    int exp_code [$];
    int exp_cyc  [$];
    int plain_q  [$];
    int cipher_q [$];
    bit record_cipher = 1'b0;

    `include "enigma_model.svh"

    enigma_top #(
        .SYM_W (SYM_W)
    ) dut_i (
        .clk          (clk),
        .srst_n       (srst_n),
        .load_i       (load_i),
        .encrypt_i    (encrypt_i),
        .crypt_mode_i (crypt_mode_i),
        .table_sel_i  (table_sel_i),
        .code_i       (code_i),
        .code_o       (code_o),
        .code_valid_o (code_valid_o)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    //==================== checks
    task automatic fail_now(string what);
        $display("%s", what);
        $display("Something failed");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic check_value(string name, int got, int expected);
        assert (got == expected) else begin
            fail_now($sformatf("CHECK FAILED at %0t: %s got %0d expected %0d",
                $time, name, got, expected));
        end
    endtask

    task automatic check_quiet();
        check_value("code_valid_o", int'(code_valid_o), 0);
        check_value("code_o", int'(code_o), 0);
    endtask

    // sampled at the falling edge where outputs are stable
    always @(negedge clk) begin
        if (srst_n === 1'b1 && code_valid_o !== 1'b0) begin
            if (exp_code.size() == 0) begin
                fail_now($sformatf("code_valid_o high at %0t with no symbol in flight", $time));
            end else begin
                check_value("code_o", int'(code_o), exp_code.pop_front());
                check_value("code_valid_o arrival cycle", cyc, exp_cyc.pop_front());
                if (record_cipher) begin
                    cipher_q.push_back(int'(code_o));
                end
            end
        end
    end

    //==================== stimulus
    task automatic apply_reset();
        @(posedge clk);
        #2;
        srst_n      = 1'b0;
        load_i      = 1'b0;
        encrypt_i   = 1'b0;
        table_sel_i = enigma_ctrl_pkg::SEL_NONE;
        repeat (16) @(posedge clk);
        #2;
        srst_n       = 1'b1;
        model_offset = 0;
    endtask

    task automatic idle_cycles(int n, bit pulses, bit quiet);
        repeat (n) begin
            @(posedge clk);
            #2;
            load_i      = 1'b0;
            table_sel_i = enigma_ctrl_pkg::SEL_NONE;
            encrypt_i   = pulses ? (rand_bits(1) == 1) : 1'b0;
            code_i      = enigma_sym_pkg::sym_t'(rand_bits(SYM_W));
            if (quiet) begin
                check_quiet();
            end
        end
    endtask

    // rotor A then rotor B
    // noisy adds SEL_NONE cycles and early encrypt pulses
    task automatic load_rotors(bit noisy);
        for (int t = 0; t < 2; t++) begin
            for (int i = 0; i < DEPTH; i++) begin
                if (noisy && rand_bits(2) == 0) begin
                    @(posedge clk);
                    #2;
                    load_i      = 1'b1;
                    table_sel_i = enigma_ctrl_pkg::SEL_NONE;
                    code_i      = enigma_sym_pkg::sym_t'(rand_bits(SYM_W));
                    encrypt_i   = (rand_bits(1) == 1);
                    check_quiet();
                end
                @(posedge clk);
                #2;
                load_i      = 1'b1;
                table_sel_i = (t == 0) ? enigma_ctrl_pkg::SEL_ROTOR_A
                                       : enigma_ctrl_pkg::SEL_ROTOR_B;
                code_i      = enigma_sym_pkg::sym_t'((t == 0) ? model_a[i] : model_b[i]);
                encrypt_i   = noisy ? (rand_bits(1) == 1) : 1'b0;
                check_quiet();
            end
        end
        // falling load moves the FSM to ready
        idle_cycles(2, 1'b0, 1'b1);
    endtask

    task automatic send_symbol(int sym, bit decrypt, int expected);
        @(posedge clk);
        #2;
        encrypt_i    = 1'b1;
        code_i       = enigma_sym_pkg::sym_t'(sym);
        crypt_mode_i = decrypt ? enigma_ctrl_pkg::MODE_DECRYPT : enigma_ctrl_pkg::MODE_ENCRYPT;
        exp_code.push_back(expected);
        // valid two edges after the accepting edge
        exp_cyc.push_back(cyc + 3);
    endtask

    task automatic stop_and_drain();
        int n;
        @(posedge clk);
        #2;
        encrypt_i = 1'b0;
        n = 0;
        while (exp_code.size() > 0 && n < DRAIN_TIMEOUT) begin
            @(posedge clk);
            n++;
        end
        if (exp_code.size() > 0) begin
            fail_now("timeout while waiting for code_valid_o on accepted symbols");
        end
    endtask

    //==================== test sequence
    initial begin
        int  sym;
        bit  mode;
        srst_n       = 1'b0;
        load_i       = 1'b0;
        encrypt_i    = 1'b0;
        crypt_mode_i = enigma_ctrl_pkg::MODE_ENCRYPT;
        table_sel_i  = enigma_ctrl_pkg::SEL_NONE;
        code_i       = '0;
        apply_reset();

        // quiet after reset and through loading
        idle_cycles(8, 1'b0, 1'b1);
        shuffle_tables();
        load_rotors(1'b0);
        // back-to-back encrypt burst
        record_cipher = 1'b1;
        for (int i = 0; i < BURST_LEN; i++) begin
            sym = rand_bits(SYM_W);
            plain_q.push_back(sym);
            send_symbol(sym, 1'b0, model_crypt(sym, 1'b0));
        end
        stop_and_drain();
        record_cipher = 1'b0;

        // gaps and mixed modes
        for (int i = 0; i < BURST_LEN; i++) begin
            mode = (rand_bits(1) == 1);
            sym  = rand_bits(SYM_W);
            send_symbol(sym, mode, model_crypt(sym, mode));
            idle_cycles(rand_bits(2), 1'b0, 1'b0);
        end
        stop_and_drain();

        // decrypt from the same start state gives the plaintext back
        apply_reset();
        idle_cycles(4, 1'b0, 1'b1);
        load_rotors(1'b0);
        for (int i = 0; i < BURST_LEN; i++) begin
            send_symbol(cipher_q[i], 1'b1, plain_q[i]);
        end
        stop_and_drain();

        // ignored selects and early encrypt pulses
        apply_reset();
        idle_cycles(8, 1'b1, 1'b1);
        shuffle_tables();
        load_rotors(1'b1);
        for (int i = 0; i < BURST_LEN; i++) begin
            mode = (rand_bits(1) == 1);
            sym  = rand_bits(SYM_W);
            send_symbol(sym, mode, model_crypt(sym, mode));
        end
        stop_and_drain();

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== enigma.f ====
+incdir+dv
common/enigma_sym_pkg.sv
common/enigma_ctrl_pkg.sv
logic/enigma_ctrl.sv
rotor/rotor_table.sv
rotor/scramble_path.sv
logic/enigma_top.sv
dv/enigma_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the enigma testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module enigma_tb -f enigma.f -o enigma_sim

# the result is taken from the simulation output
out=$(./obj_dir/enigma_sim 2>&1) || true
echo "$out"
if grep -qx "Everything OK" <<< "$out"; then
    exit 0
fi
exit 1
